//--- rtl/ctrl_pkg.sv
/*
  Pipeline control definitions shared by the controller FSM and the
  hazard unit. Holds the state encoding, the PC source select, the jump
  kinds, the forwarding select and the trap cause layout.
  Modules import it with a wildcard inside the module body.
*/
package ctrl_pkg;

  // controller FSM states
  typedef enum logic [2:0] {
    RESET, BOOT_SET, FIRST_FETCH, DECODE,
    IRQ_FLUSH, IRQ_TAKEN, FLUSH_EX, FLUSH_WB
  } ctrl_state_t;

  // PC source select towards the fetch stage
  typedef logic [2:0] pc_mux_t;
  localparam pc_mux_t PC_BOOT      = 3'b000;
  localparam pc_mux_t PC_JUMP      = 3'b010;
  localparam pc_mux_t PC_BRANCH    = 3'b011;
  localparam pc_mux_t PC_EXCEPTION = 3'b100;
  localparam pc_mux_t PC_MRET      = 3'b101;

  // jump kind of the instruction in decode
  typedef logic [1:0] jump_t;
  localparam jump_t BRANCH_NONE = 2'b00;
  localparam jump_t BRANCH_JAL  = 2'b01;
  localparam jump_t BRANCH_JALR = 2'b10;
  localparam jump_t BRANCH_COND = 2'b11;

  // operand source in ID
  typedef logic [1:0] fw_sel_t;
  localparam fw_sel_t SEL_REGFILE = 2'b00;
  localparam fw_sel_t SEL_FW_EX   = 2'b01;
  localparam fw_sel_t SEL_FW_WB   = 2'b10;

  // bit 5 flags an interrupt, bits 4:0 carry the interrupt id
  typedef logic [5:0] exc_cause_t;
  typedef logic [4:0] irq_id_t;
  localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN = 6'd2;
  localparam exc_cause_t EXC_CAUSE_BREAKPOINT   = 6'd3;
  localparam exc_cause_t EXC_CAUSE_ECALL_MMODE  = 6'd11;

  // one hit bit per source operand
  typedef logic [2:0] operand_hit_t;
  localparam int unsigned OP_A = 0;
  localparam int unsigned OP_B = 1;
  localparam int unsigned OP_C = 2;

endpackage

//--- rtl/ctrl_regs_pkg.sv
/*
  APB types, register offsets and field positions of the controller
  register block. The FSM uses the trap-enable positions as well.
*/
package ctrl_regs_pkg;

  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // register map
  localparam apb_addr_t REG_CTRL    = 4'h0;
  localparam apb_addr_t REG_TRAP_EN = 4'h4;
  localparam apb_addr_t REG_CAUSE   = 4'h8;

  // CTRL fields
  localparam int unsigned CTRL_FETCH_EN = 0;
  localparam int unsigned CTRL_MIE      = 1;
  localparam int unsigned CTRL_MPIE     = 2;

  // debug trap enables, one per instruction kind
  typedef logic [2:0] trap_en_t;
  localparam int unsigned TRAP_EN_EBRK  = 0;
  localparam int unsigned TRAP_EN_ECALL = 1;
  localparam int unsigned TRAP_EN_ILL   = 2;

endpackage

//--- rtl/trap_if.sv
/*
  Link between the controller FSM and the register block. The register
  side supplies the enables, the FSM side reports trap entry and mret.
*/
interface trap_if;

  // register block to FSM
  logic                    fetch_en;
  logic                    mie;
  ctrl_regs_pkg::trap_en_t trap_en;

  // FSM to register block, single cycle pulses
  logic                    save_cause;
  ctrl_pkg::exc_cause_t    cause;
  logic                    restore_mret;

  modport fsm (
    input  fetch_en, mie, trap_en,
    output save_cause, cause, restore_mret
  );

  modport regs (
    output fetch_en, mie, trap_en,
    input  save_cause, cause, restore_mret
  );

endinterface

//--- rtl/ctrl_fsm.sv
/*
  Main pipeline controller. Boots on fetch enable, redirects the PC on
  branches, jumps, traps and mret, flushes the pipe for exceptions and
  ebreak, and takes machine interrupts from the ID stage.
*/
module ctrl_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid_i,
  input  logic                  illegal_insn_i,
  input  logic                  ecall_insn_i,
  input  logic                  ebrk_insn_i,
  input  logic                  mret_insn_i,
  input  logic                  branch_taken_ex_i,
  input  ctrl_pkg::jump_t       jump_in_dec_i,
  input  logic                  id_ready_i,
  input  logic                  ex_valid_i,
  input  logic                  irq_req_i,
  input  ctrl_pkg::irq_id_t     irq_id_i,
  input  logic                  jr_stall_i,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_mux_t     pc_mux_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o,
  output logic                  is_decoding_o,
  output logic                  irq_ack_o,
  output logic                  dbg_trap_o,
  trap_if.fsm                   trap
);
  import ctrl_pkg::*;
  import ctrl_regs_pkg::*;

  ctrl_state_t state_q, state_d;
  logic        jump_done_q, jump_done_d;
  logic        jump_in_dec;
  logic        irq_pending;

  assign jump_in_dec = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);
  // enable is checked again in IRQ_FLUSH since mie may change under us
  assign irq_pending = irq_req_i & trap.mie;

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_d           = state_q;
    jump_done_d       = jump_done_q;
    instr_req_o       = 1'b1;
    pc_set_o          = 1'b0;
    pc_mux_o          = PC_BOOT;
    halt_if_o         = 1'b0;
    halt_id_o         = 1'b0;
    is_decoding_o     = 1'b0;
    irq_ack_o         = 1'b0;
    dbg_trap_o        = 1'b0;
    trap.save_cause   = 1'b0;
    trap.cause        = '0;
    trap.restore_mret = 1'b0;

    unique case (state_q)
      // idle until software sets fetch enable
      RESET:
      begin
        instr_req_o = 1'b0;
        if (trap.fetch_en)
          state_d = BOOT_SET;
      end
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end
      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        if (id_ready_i)
          state_d = DECODE;
      end
      DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // branch resolved in EX wins over anything in ID
          pc_mux_o = PC_BRANCH;
          pc_set_o = 1'b1;
        end
        else if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;
          if (irq_pending)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = IRQ_FLUSH;
          end
          else if (jump_in_dec)
          begin
            // target known in ID so redirect once the jr hazard is gone
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (ebrk_insn_i)
          begin
            // ebreak only flushes and is not recorded as a cause
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
          else if (ecall_insn_i || illegal_insn_i)
          begin
            halt_if_o       = 1'b1;
            halt_id_o       = 1'b1;
            trap.save_cause = 1'b1;
            trap.cause      = ecall_insn_i ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ILLEGAL_INSN;
            state_d         = FLUSH_EX;
          end
          else if (mret_insn_i)
          begin
            halt_if_o         = 1'b1;
            halt_id_o         = 1'b1;
            trap.restore_mret = 1'b1;
            state_d           = FLUSH_EX;
          end
        end
      end
      // drain EX before redirecting
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end
      // instruction is still held in ID by halt_id
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ecall_insn_i)
        begin
          pc_mux_o   = PC_EXCEPTION;
          pc_set_o   = 1'b1;
          dbg_trap_o = trap.trap_en[TRAP_EN_ECALL];
        end
        else if (illegal_insn_i)
        begin
          pc_mux_o   = PC_EXCEPTION;
          pc_set_o   = 1'b1;
          dbg_trap_o = trap.trap_en[TRAP_EN_ILL];
        end
        else if (mret_insn_i)
        begin
          pc_mux_o = PC_MRET;
          pc_set_o = 1'b1;
        end
        else if (ebrk_insn_i)
          dbg_trap_o = trap.trap_en[TRAP_EN_EBRK];
        state_d = DECODE;
      end
      IRQ_FLUSH:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        // request withdrawn so resume with the instruction in ID
        state_d   = irq_pending ? IRQ_TAKEN : DECODE;
      end
      IRQ_TAKEN:
      begin
        pc_mux_o        = PC_EXCEPTION;
        pc_set_o        = 1'b1;
        irq_ack_o       = 1'b1;
        trap.save_cause = 1'b1;
        trap.cause      = {1'b1, irq_id_i};
        state_d         = DECODE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // jump stays done until ID accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

//--- rtl/hazard_unit.sv
/*
  Data hazard logic for the ID stage. Detects load-use and jump-register
  stalls, drops the register write enable and selects forwarding sources.
  Purely combinational.
*/
module hazard_unit (
  input  logic                   is_decoding_i,
  input  logic                   illegal_insn_i,
  input  ctrl_pkg::jump_t        jump_in_dec_i,
  input  logic                   data_req_ex_i,
  input  logic                   regfile_we_ex_i,
  input  logic                   regfile_we_wb_i,
  input  logic                   regfile_alu_we_fw_i,
  input  logic                   wb_ready_i,
  input  ctrl_pkg::operand_hit_t hit_ex_i,
  input  ctrl_pkg::operand_hit_t hit_wb_i,
  input  ctrl_pkg::operand_hit_t hit_alu_i,
  output logic                   load_stall_o,
  output logic                   jr_stall_o,
  output logic                   deassert_we_o,
  output ctrl_pkg::fw_sel_t      fw_sel_a_o,
  output ctrl_pkg::fw_sel_t      fw_sel_b_o,
  output ctrl_pkg::fw_sel_t      fw_sel_c_o
);
  import ctrl_pkg::*;

  operand_hit_t fw_wb;
  operand_hit_t fw_alu;

  // ALU result is younger than WB, so it wins
  function automatic fw_sel_t fw_select(input logic wb_hit, input logic alu_hit);
    fw_sel_t sel;
    sel = SEL_REGFILE;
    if (wb_hit)
      sel = SEL_FW_WB;
    if (alu_hit)
      sel = SEL_FW_EX;
    return sel;
  endfunction

  // load in EX, or a load stuck in WB, feeding an ID operand
  assign load_stall_o = ((data_req_ex_i & regfile_we_ex_i) | (~wb_ready_i & regfile_we_wb_i))
                        & (|hit_ex_i);

  // jalr target register still in flight anywhere down the pipe
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) &&
                      ((hit_wb_i[OP_A] & regfile_we_wb_i) |
                       (hit_ex_i[OP_A] & regfile_we_ex_i) |
                       (hit_alu_i[OP_A] & regfile_alu_we_fw_i));

  assign deassert_we_o = ~is_decoding_i | illegal_insn_i | load_stall_o | jr_stall_o;

  // hits that come with a live write enable
  assign fw_wb  = hit_wb_i & {3{regfile_we_wb_i}};
  assign fw_alu = hit_alu_i & {3{regfile_alu_we_fw_i}};

  assign fw_sel_a_o = fw_select(fw_wb[OP_A], fw_alu[OP_A]);
  assign fw_sel_b_o = fw_select(fw_wb[OP_B], fw_alu[OP_B]);
  assign fw_sel_c_o = fw_select(fw_wb[OP_C], fw_alu[OP_C]);

endmodule

//--- rtl/ctrl_csr_regs.sv
/*
  APB register block beside the controller. Holds fetch enable, the
  interrupt enable and its saved copy, the debug trap enables and the last
  trap cause. No wait states; CAUSE is read only.
*/
module ctrl_csr_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  ctrl_regs_pkg::apb_addr_t paddr_i,
  input  ctrl_regs_pkg::apb_data_t pwdata_i,
  output ctrl_regs_pkg::apb_data_t prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  trap_if.regs                     trap
);
  import ctrl_pkg::*;
  import ctrl_regs_pkg::*;

  logic       fetch_en_q, mie_q, mpie_q;
  trap_en_t   trap_en_q;
  exc_cause_t cause_q;
  logic       access, mapped, wr_ctrl, wr_trap_en, irq_save;

  ////////////////////////////////////////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////////////////////////////////////////
  assign access     = psel_i & penable_i;
  assign mapped     = (paddr_i == REG_CTRL) || (paddr_i == REG_TRAP_EN) || (paddr_i == REG_CAUSE);
  assign wr_ctrl    = access & pwrite_i & (paddr_i == REG_CTRL);
  assign wr_trap_en = access & pwrite_i & (paddr_i == REG_TRAP_EN);
  assign pready_o   = 1'b1;
  assign pslverr_o  = access & (~mapped | (pwrite_i & (paddr_i == REG_CAUSE)));

  always_comb
  begin
    prdata_o = '0;
    case (paddr_i)
      REG_CTRL:
      begin
        prdata_o[CTRL_FETCH_EN] = fetch_en_q;
        prdata_o[CTRL_MIE]      = mie_q;
        prdata_o[CTRL_MPIE]     = mpie_q;
      end
      REG_TRAP_EN: prdata_o[$bits(trap_en_t)-1:0] = trap_en_q;
      REG_CAUSE:   prdata_o[$bits(exc_cause_t)-1:0] = cause_q;
      default:     prdata_o = '0;
    endcase
  end

  // only an interrupt entry touches the enable stack
  assign irq_save = trap.save_cause & trap.cause[5];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fetch_en_q <= 1'b0;
      mie_q      <= 1'b0;
      mpie_q     <= 1'b0;
      trap_en_q  <= '0;
      cause_q    <= '0;
    end
    else
    begin
      if (wr_ctrl)
        fetch_en_q <= pwdata_i[CTRL_FETCH_EN];
      if (wr_trap_en)
        trap_en_q <= pwdata_i[$bits(trap_en_t)-1:0];
      if (trap.save_cause)
        cause_q <= trap.cause;
      // trap side beats a software write of mie or mpie
      if (irq_save)
      begin
        mpie_q <= mie_q;
        mie_q  <= 1'b0;
      end
      else if (trap.restore_mret)
      begin
        mie_q  <= mpie_q;
        mpie_q <= 1'b1;
      end
      else if (wr_ctrl)
      begin
        mie_q  <= pwdata_i[CTRL_MIE];
        mpie_q <= pwdata_i[CTRL_MPIE];
      end
    end
  end

  assign trap.fetch_en = fetch_en_q;
  assign trap.mie      = mie_q;
  assign trap.trap_en  = trap_en_q;

endmodule

//--- rtl/core_ctrl_top.sv
/*
  Top level of the pipeline controller. Joins the controller FSM, the
  hazard unit and the APB register block; everything outside sees plain
  ports only.
*/
module core_ctrl_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // APB slave
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  ctrl_regs_pkg::apb_addr_t paddr_i,
  input  ctrl_regs_pkg::apb_data_t pwdata_i,
  output ctrl_regs_pkg::apb_data_t prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  // decode and pipeline status
  input  logic                     instr_valid_i,
  input  logic                     illegal_insn_i,
  input  logic                     ecall_insn_i,
  input  logic                     ebrk_insn_i,
  input  logic                     mret_insn_i,
  input  logic                     branch_taken_ex_i,
  input  ctrl_pkg::jump_t          jump_in_dec_i,
  input  logic                     id_ready_i,
  input  logic                     ex_valid_i,
  input  logic                     irq_req_i,
  input  ctrl_pkg::irq_id_t        irq_id_i,
  // operand hazards
  input  logic                     data_req_ex_i,
  input  logic                     regfile_we_ex_i,
  input  logic                     regfile_we_wb_i,
  input  logic                     regfile_alu_we_fw_i,
  input  logic                     wb_ready_i,
  input  ctrl_pkg::operand_hit_t   hit_ex_i,
  input  ctrl_pkg::operand_hit_t   hit_wb_i,
  input  ctrl_pkg::operand_hit_t   hit_alu_i,
  // fetch and pipeline control
  output logic                     instr_req_o,
  output logic                     pc_set_o,
  output ctrl_pkg::pc_mux_t        pc_mux_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o,
  output logic                     is_decoding_o,
  output logic                     irq_ack_o,
  output logic                     dbg_trap_o,
  output logic                     load_stall_o,
  output logic                     jr_stall_o,
  output logic                     deassert_we_o,
  output ctrl_pkg::fw_sel_t        fw_sel_a_o,
  output ctrl_pkg::fw_sel_t        fw_sel_b_o,
  output ctrl_pkg::fw_sel_t        fw_sel_c_o
);

  trap_if trap ();

  // jr stall from the hazard unit gates the jump redirect
  ctrl_fsm i_fsm (
    .jr_stall_i (jr_stall_o),
    .trap       (trap),
    .*
  );

  hazard_unit i_hazard (
    .is_decoding_i (is_decoding_o),
    .*
  );

  ctrl_csr_regs i_regs (
    .trap (trap),
    .*
  );

endmodule

//--- test/core_ctrl_properties.sv
/*
  Concurrent checks on the controller FSM, bound into every ctrl_fsm
  instance from the testbench side.
*/
module core_ctrl_properties (
  input logic                  clk,
  input logic                  rst_n,
  input ctrl_pkg::ctrl_state_t state_q,
  input logic                  irq_ack_o,
  input logic                  halt_id_o,
  input logic                  pc_set_o
);
  import ctrl_pkg::*;

  // acknowledge is a single cycle pulse
  a_irq_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_o |=> !irq_ack_o) else $error("irq_ack_o high for two cycles");

  a_halt_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == FLUSH_EX) |-> halt_id_o) else $error("halt_id_o low in FLUSH_EX");

  a_no_redirect_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == RESET) |-> !pc_set_o) else $error("pc_set_o high in RESET");

endmodule

bind ctrl_fsm core_ctrl_properties i_props (.*);

//--- test/core_ctrl_tb.sv
/*
  Testbench for the pipeline controller top level. Reads one scenario per
  line from the cases file, drives the DUT on the falling clock edge and
  compares the responses with the expected values given on each line.
  Run from the project root so that the cases file is found.
*/
module core_ctrl_tb;
  import ctrl_pkg::*;
  import ctrl_regs_pkg::*;

  localparam int TIMEOUT = 40;

  logic         clk, rst_n;
  logic         psel_i, penable_i, pwrite_i;
  apb_addr_t    paddr_i;
  apb_data_t    pwdata_i, prdata_o;
  logic         pready_o, pslverr_o;
  logic         instr_valid_i, illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i;
  logic         branch_taken_ex_i, id_ready_i, ex_valid_i, irq_req_i;
  jump_t        jump_in_dec_i;
  irq_id_t      irq_id_i;
  logic         data_req_ex_i, regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic         wb_ready_i;
  operand_hit_t hit_ex_i, hit_wb_i, hit_alu_i;
  logic         instr_req_o, pc_set_o, halt_if_o, halt_id_o, is_decoding_o;
  logic         irq_ack_o, dbg_trap_o, load_stall_o, jr_stall_o, deassert_we_o;
  pc_mux_t      pc_mux_o;
  fw_sel_t      fw_sel_a_o, fw_sel_b_o, fw_sel_c_o;

  core_ctrl_top i_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp));
  endtask

  // one APB transfer with setup and access phase and no wait states
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    @(negedge clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk);
    penable_i = 1'b1;
    #1;
    rdata = prdata_o;
    err   = pslverr_o;
    check("pready_o", pready_o, 1);
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic reg_expect(input apb_addr_t addr, input apb_data_t exp, input string name);
    apb_data_t rd;
    logic      err;
    apb_access(1'b0, addr, '0, rd, err);
    check({name, " pslverr"}, err, 0);
    check(name, rd, exp);
  endtask

  task automatic clear_decode;
    instr_valid_i  = 1'b0;
    illegal_insn_i = 1'b0;
    ecall_insn_i   = 1'b0;
    ebrk_insn_i    = 1'b0;
    mret_insn_i    = 1'b0;
    irq_req_i      = 1'b0;
    ex_valid_i     = 1'b0;
    jump_in_dec_i  = BRANCH_NONE;
    hit_wb_i       = '0;
    regfile_we_wb_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // scenarios
  ////////////////////////////////////////////////////////////////////////////
  task automatic access_register(input logic [31:0] a, b, c, d, e);
    apb_data_t rd;
    logic      err;
    apb_access(1'b1, a[3:0], b, rd, err);
    check("pslverr_o on write", err, d);
    apb_access(1'b0, a[3:0], '0, rd, err);
    check("pslverr_o on read", err, e);
    if (e == 0)
      check("prdata_o", rd, c);
  endtask

  task automatic boot_core(input logic [31:0] a);
    apb_data_t rd;
    logic      err;
    int        n;
    // still idle while fetch is off
    repeat (3)
    begin
      @(negedge clk);
      #1;
      check("instr_req_o", instr_req_o, 0);
      check("pc_set_o", pc_set_o, 0);
    end
    apb_access(1'b1, REG_CTRL, a, rd, err);
    n = 0;
    #1;
    while (!pc_set_o)
    begin
      if (n > TIMEOUT)
        abort_run("timeout: no boot redirect after fetch enable");
      @(negedge clk);
      #1;
      n++;
    end
    check("pc_mux_o", pc_mux_o, PC_BOOT);
    check("instr_req_o", instr_req_o, 1);
    @(negedge clk);
    id_ready_i = 1'b1;
    #1;
    check("pc_set_o", pc_set_o, 0);
    check("instr_req_o", instr_req_o, 1);
    @(negedge clk);
    id_ready_i = 1'b0;
    repeat (3)
    begin
      #1;
      check("instr_req_o", instr_req_o, 1);
      check("pc_set_o", pc_set_o, 0);
      @(negedge clk);
    end
  endtask

  // kind in a (0 illegal, 1 ecall, 2 ebreak) with trap enables in b and ex delay in c
  task automatic flush_exception(input logic [31:0] a, b, c, d, e);
    apb_data_t rd;
    logic      err, prev_ex, done, dbg;
    int        n;
    apb_access(1'b1, REG_TRAP_EN, b, rd, err);
    @(negedge clk);
    instr_valid_i  = 1'b1;
    illegal_insn_i = (a == 0);
    ecall_insn_i   = (a == 1);
    ebrk_insn_i    = (a == 2);
    #1;
    check("halt_id_o", halt_id_o, 1);
    check("halt_if_o", halt_if_o, 1);
    check("is_decoding_o", is_decoding_o, 1);
    dbg     = dbg_trap_o;
    prev_ex = 1'b0;
    done    = 1'b0;
    n       = 0;
    while (!done)
    begin
      if (n > TIMEOUT)
        abort_run("timeout: exception flush did not finish");
      @(negedge clk);
      ex_valid_i = (n >= c);
      n++;
      #1;
      // both halts stay up for the whole flush
      check("halt_if_o", halt_if_o, 1);
      check("halt_id_o", halt_id_o, 1);
      if (dbg_trap_o)
        dbg = 1'b1;
      // the cycle after ex_valid is the last flush cycle
      if (prev_ex)
      begin
        check("pc_set_o", pc_set_o, a != 2);
        if (pc_set_o)
          check("pc_mux_o", pc_mux_o, PC_EXCEPTION);
        done = 1'b1;
      end
      prev_ex = ex_valid_i;
    end
    @(negedge clk);
    clear_decode();
    check("dbg_trap_o seen", dbg, e);
    if (d != 32'hff)
      reg_expect(REG_CAUSE, d, "CAUSE");
  endtask

  task automatic take_interrupt(input logic [31:0] a, b, c, d, e);
    apb_data_t rd;
    logic      err;
    int        n;
    apb_access(1'b1, REG_CTRL, 32'h1 | (b << CTRL_MIE), rd, err);
    @(negedge clk);
    instr_valid_i = 1'b1;
    irq_req_i     = 1'b1;
    irq_id_i      = a[4:0];
    #1;
    if (b == 0)
    begin
      // masked request must never be acknowledged
      for (n = 0; n < TIMEOUT / 4; n++)
      begin
        check("irq_ack_o", irq_ack_o, 0);
        @(negedge clk);
        #1;
      end
      clear_decode();
      return;
    end
    n = 0;
    while (!irq_ack_o)
    begin
      if (n > TIMEOUT)
        abort_run("timeout: interrupt was not acknowledged");
      @(negedge clk);
      #1;
      n++;
    end
    check("pc_set_o", pc_set_o, 1);
    check("pc_mux_o", pc_mux_o, PC_EXCEPTION);
    @(negedge clk);
    clear_decode();
    reg_expect(REG_CAUSE, c, "CAUSE");
    reg_expect(REG_CTRL, d, "CTRL after interrupt");
    // return from the handler
    @(negedge clk);
    instr_valid_i = 1'b1;
    mret_insn_i   = 1'b1;
    ex_valid_i    = 1'b1;
    #1;
    n = 0;
    while (!pc_set_o)
    begin
      if (n > TIMEOUT)
        abort_run("timeout: mret gave no redirect");
      @(negedge clk);
      #1;
      n++;
    end
    check("pc_mux_o", pc_mux_o, PC_MRET);
    @(negedge clk);
    clear_decode();
    reg_expect(REG_CTRL, e, "CTRL after mret");
  endtask

  // flag nibbles in a hold data_req, we_ex, we_wb, alu_we and wb_ready
  // nibbles in b hold jump, hit_ex, hit_wb and hit_alu
  task automatic compare_forwarding(input logic [31:0] a, b, c, d, e);
    @(negedge clk);
    instr_valid_i       = 1'b0;
    data_req_ex_i       = a[16];
    regfile_we_ex_i     = a[12];
    regfile_we_wb_i     = a[8];
    regfile_alu_we_fw_i = a[4];
    wb_ready_i          = a[0];
    jump_in_dec_i       = b[13:12];
    hit_ex_i            = b[10:8];
    hit_wb_i            = b[6:4];
    hit_alu_i           = b[2:0];
    #1;
    check("is_decoding_o", is_decoding_o, 0);
    check("fw_sel_a_o", fw_sel_a_o, c[9:8]);
    check("fw_sel_b_o", fw_sel_b_o, c[5:4]);
    check("fw_sel_c_o", fw_sel_c_o, c[1:0]);
    check("load_stall_o", load_stall_o, d[4]);
    check("jr_stall_o", jr_stall_o, d[0]);
    check("deassert_we_o", deassert_we_o, e);
    @(negedge clk);
    data_req_ex_i       = 1'b0;
    regfile_we_ex_i     = 1'b0;
    regfile_alu_we_fw_i = 1'b0;
    wb_ready_i          = 1'b1;
    hit_ex_i            = '0;
    hit_alu_i           = '0;
    clear_decode();
  endtask

  // jump kind in a, cycles of the WB hit on operand a in b, cycles before id_ready in c
  task automatic count_jump_pulses(input logic [31:0] a, b, c, d);
    int k, pulses;
    pulses = 0;
    for (k = 0; k < c; k++)
    begin
      @(negedge clk);
      instr_valid_i   = 1'b1;
      jump_in_dec_i   = a[1:0];
      hit_wb_i        = {2'b00, k < b};
      regfile_we_wb_i = (k < b);
      #1;
      if (pc_set_o && pc_mux_o == PC_JUMP)
      begin
        pulses++;
        if (k < b)
          abort_run("jump redirect came while the jr hazard was still present");
      end
    end
    check("jump pulses", pulses, d);
    @(negedge clk);
    id_ready_i = 1'b1;
    @(negedge clk);
    id_ready_i = 1'b0;
    clear_decode();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    int          fd, r;
    string       line;
    logic [63:0] kind;
    logic [31:0] a, b, c, d, e;
    rst_n = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    branch_taken_ex_i = 1'b0;
    id_ready_i = 1'b0;
    irq_id_i = '0;
    data_req_ex_i = 1'b0;
    regfile_we_ex_i = 1'b0;
    regfile_alu_we_fw_i = 1'b0;
    wb_ready_i = 1'b1;
    hit_ex_i = '0;
    hit_alu_i = '0;
    clear_decode();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("test/ctrl_cases.txt", "r");
    if (fd == 0)
      abort_run("cannot open test/ctrl_cases.txt");
    while (!$feof(fd))
    begin
      r = $fgets(line, fd);
      if (r == 0 || line.len() < 3 || line.substr(0, 0) == "#")
        continue;
      a = 0;
      b = 0;
      c = 0;
      d = 0;
      e = 0;
      r = $sscanf(line, "%s %h %h %h %h %h", kind, a, b, c, d, e);
      if (kind == "APB")
        access_register(a, b, c, d, e);
      else if (kind == "BOOT")
        boot_core(a);
      else if (kind == "EXC")
        flush_exception(a, b, c, d, e);
      else if (kind == "IRQ")
        take_interrupt(a, b, c, d, e);
      else if (kind == "FWD")
        compare_forwarding(a, b, c, d, e);
      else if (kind == "JUMP")
        count_jump_pulses(a, b, c, d);
      else
        abort_run({"unknown case kind in line: ", line});
    end
    $fclose(fd);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- test/ctrl_cases.txt
# kind then five hex fields a b c d e, meaning depends on kind
# APB addr wdata rdata werr rerr / EXC kind trap_en delay cause dbg / IRQ id mie cause ctrl ctrl
APB 4 ff 7 0 0
APB 0 6 6 0 0
APB 0 0 0 0 0
APB 8 1 0 1 0
APB c 1 0 1 1
BOOT 1 0 0 0 0
EXC 0 4 2 2 1
EXC 1 0 0 b 0
EXC 1 2 3 b 1
EXC 2 1 1 ff 1
EXC 2 0 0 ff 0
IRQ 5 1 25 5 7
IRQ 3 0 0 0 0
IRQ 1f 1 3f 5 7
FWD 00001 0000 000 00 1
FWD 00111 0036 211 00 1
FWD 11001 0200 000 10 1
FWD 00100 0140 002 10 1
FWD 00011 2001 100 01 1
FWD 00001 2100 000 00 1
JUMP 1 0 4 1 0
JUMP 2 3 6 1 0

//--- src.f
rtl/ctrl_pkg.sv
rtl/ctrl_regs_pkg.sv
rtl/trap_if.sv
rtl/ctrl_fsm.sv
rtl/hazard_unit.sv
rtl/ctrl_csr_regs.sv
rtl/core_ctrl_top.sv
test/core_ctrl_properties.sv
test/core_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module core_ctrl_tb -f src.f -o core_ctrl_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/core_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
